// File: src/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// ------------------------------
// machine trap setup and handling
// ------------------------------
`define CSR_MSTATUS    12'h300
`define CSR_MISA       12'h301
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343

// ------------------------------
// machine and user counters
// ------------------------------
`define CSR_MCYCLE     12'hB00
`define CSR_MINSTRET   12'hB02
`define CSR_MCYCLEH    12'hB80
`define CSR_MINSTRETH  12'hB82
`define CSR_CYCLE      12'hC00
`define CSR_TIME       12'hC01
`define CSR_INSTRET    12'hC02
`define CSR_CYCLEH     12'hC80
`define CSR_TIMEH      12'hC81
`define CSR_INSTRETH   12'hC82

// ------------------------------
// not implemented, read as zero
// ------------------------------
`define CSR_MIP        12'h344
`define CSR_PMPCFG0    12'h3A0
`define CSR_PMPADDR0   12'h3B0
`define CSR_MVENDORID  12'hF11
`define CSR_MHARTID    12'hF14

// MXL = 01 (32-bit) in bits 31:30, I extension in bit 8.
`define CSR_MISA_VALUE 32'h4000_0100

// fixed MPP field of mstatus, machine mode only.
`define CSR_MSTATUS_MPP 2'b11

`endif

// File: src/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    // ------------------------------
    // address and access control
    // ------------------------------

    typedef logic [11:0] csr_addr_t; // csr number from the instruction.

    // csrrw/csrrs/csrrc and their immediate forms.
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b00, // replace.
        CSR_OP_RS = 2'b01, // set bits.
        CSR_OP_RC = 2'b10  // clear bits.
    } csr_write_op_e;

    // operand comes from rs1 or the zimm field.
    typedef enum logic {
        CSR_SRC_IMM = 1'b0,
        CSR_SRC_REG = 1'b1
    } csr_src_e;

endpackage

`default_nettype wire

// File: src/csr_data_pkg.sv
`default_nettype none

package csr_data_pkg;

    typedef logic [31:0] csr_word_t;     // one csr data word.
    typedef logic [63:0] csr_counter_t;  // full cycle or instret count.
    typedef logic [29:0] word_aligned_t; // bits 31:2 of a word address.
    typedef logic [3:0]  cause_code_t;   // exception or interrupt code.

endpackage

`default_nettype wire

// File: src/csr_access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_access_if;
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    csr_addr_t addr;      // decoded by every bank.
    csr_word_t new_value; // value after the read-modify step.
    logic      write_en;  // strobe already gated by stall.
    csr_word_t read_data; // zero when the bank does not hit.
    logic      hit;

    modport bank (
        input  addr,
        input  new_value,
        input  write_en,
        output read_data,
        output hit
    );

    modport host (
        output addr,
        output new_value,
        output write_en,
        input  read_data,
        input  hit
    );

endinterface

`default_nettype wire

// File: src/csr_machine_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_machine_regs (
    input  wire         clk,
    input  wire         arst_n,
    csr_access_if.bank  bus
);
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    csr_addr_t     addr;

    logic          mstatus_mie;
    logic          mstatus_mpie;
    logic          mie_msie;
    logic          mie_mtie;
    logic          mie_meie;
    word_aligned_t mtvec_base;
    logic          mtvec_mode;
    csr_word_t     mscratch;
    word_aligned_t mepc;
    logic          mcause_interrupt;
    cause_code_t   mcause_code;
    csr_word_t     mtval;

    assign addr = bus.addr;

    // ------------------------------
    // read decode
    // ------------------------------
    always_comb begin
        bus.hit       = 1'b1;
        bus.read_data = '0;
        case (addr)
            `CSR_MSTATUS: begin
                bus.read_data = {19'b0, `CSR_MSTATUS_MPP, 3'b0, mstatus_mpie,
                                 3'b0, mstatus_mie, 3'b0};
            end
            `CSR_MISA: begin
                bus.read_data = `CSR_MISA_VALUE;
            end
            `CSR_MIE: begin
                bus.read_data = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
            end
            `CSR_MTVEC: begin
                bus.read_data = {mtvec_base, 1'b0, mtvec_mode}; // bit 1 is reserved.
            end
            `CSR_MSCRATCH: begin
                bus.read_data = mscratch;
            end
            `CSR_MEPC: begin
                bus.read_data = {mepc, 2'b00};
            end
            `CSR_MCAUSE: begin
                bus.read_data = {mcause_interrupt, 27'b0, mcause_code};
            end
            `CSR_MTVAL: begin
                bus.read_data = mtval;
            end
            default: begin
                bus.hit = 1'b0; // left to the other bank or read as zero.
            end
        endcase
    end

    // ------------------------------
    // field writes
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_mie      <= 1'b0;
            mstatus_mpie     <= 1'b0;
            mie_msie         <= 1'b0;
            mie_mtie         <= 1'b0;
            mie_meie         <= 1'b0;
            mtvec_base       <= '0;
            mtvec_mode       <= 1'b0;
            mscratch         <= '0;
            mepc             <= '0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= '0;
            mtval            <= '0;
        end else if (bus.write_en) begin
            case (addr)
                `CSR_MSTATUS: begin
                    mstatus_mpie <= bus.new_value[7];
                    mstatus_mie  <= bus.new_value[3];
                end
                `CSR_MIE: begin
                    mie_meie <= bus.new_value[11];
                    mie_mtie <= bus.new_value[7];
                    mie_msie <= bus.new_value[3];
                end
                `CSR_MTVEC: begin
                    mtvec_base <= bus.new_value[31:2];
                    mtvec_mode <= bus.new_value[0]; // direct or vectored.
                end
                `CSR_MSCRATCH: begin
                    mscratch <= bus.new_value;
                end
                `CSR_MEPC: begin
                    mepc <= bus.new_value[31:2];
                end
                `CSR_MCAUSE: begin
                    mcause_interrupt <= bus.new_value[31];
                    mcause_code      <= bus.new_value[3:0];
                end
                `CSR_MTVAL: begin
                    mtval <= bus.new_value;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_counters (
    input  wire                        clk,
    input  wire                        arst_n,
    input  logic                       instr_retired,
    csr_access_if.bank                 bus,
    output csr_data_pkg::csr_counter_t cycle
);
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    csr_addr_t    addr;
    csr_counter_t cycle_count;
    csr_counter_t instret_count;

    assign addr  = bus.addr;
    assign cycle = cycle_count;

    // ------------------------------
    // counters
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count   <= cycle_count + 64'd1; // runs through stalls.
            instret_count <= instret_count + csr_counter_t'(instr_retired);
        end
    end

    // time has no separate timer and follows cycle.
    always_comb begin
        bus.hit       = 1'b1;
        bus.read_data = '0;
        case (addr)
            `CSR_MCYCLE, `CSR_CYCLE, `CSR_TIME: begin
                bus.read_data = cycle_count[31:0];
            end
            `CSR_MCYCLEH, `CSR_CYCLEH, `CSR_TIMEH: begin
                bus.read_data = cycle_count[63:32];
            end
            `CSR_MINSTRET, `CSR_INSTRET: begin
                bus.read_data = instret_count[31:0];
            end
            `CSR_MINSTRETH, `CSR_INSTRETH: begin
                bus.read_data = instret_count[63:32];
            end
            default: begin
                bus.hit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                          clk,
    input  wire                          arst_n,
    input  logic                         stall,
    input  logic                         write,
    input  csr_addr_pkg::csr_write_op_e  write_op,
    input  csr_addr_pkg::csr_src_e       src,
    input  logic                         instr_retired,
    input  csr_addr_pkg::csr_addr_t      csr,
    input  csr_data_pkg::csr_word_t      rs1_value,
    input  csr_data_pkg::csr_word_t      imm_value,
    output csr_data_pkg::csr_word_t      read_value,
    output csr_data_pkg::csr_counter_t   cycle
);
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    csr_word_t operand;
    csr_word_t merged_read;
    csr_word_t new_value;
    logic      write_en;

    csr_access_if machine_bus ();
    csr_access_if counter_bus ();

    // ------------------------------
    // operand and write strobe
    // ------------------------------
    assign operand  = (src == CSR_SRC_REG) ? rs1_value : imm_value;
    assign write_en = write && !stall; // stalled writes are dropped.

    // ------------------------------
    // read merge
    // ------------------------------
    // banks decode disjoint ranges, so at most one hits.
    assign merged_read = (machine_bus.hit ? machine_bus.read_data : '0)
                       | (counter_bus.hit ? counter_bus.read_data : '0);
    assign read_value  = merged_read;

    always_comb begin
        case (write_op)
            CSR_OP_RW: new_value = operand;
            CSR_OP_RS: new_value = merged_read | operand;
            CSR_OP_RC: new_value = merged_read & ~operand;
            default:   new_value = merged_read; // unused encoding keeps the value.
        endcase
    end

    // ------------------------------
    // bank buses
    // ------------------------------
    assign machine_bus.addr      = csr;
    assign machine_bus.new_value = new_value;
    assign machine_bus.write_en  = write_en;

    assign counter_bus.addr      = csr;
    assign counter_bus.new_value = new_value;
    assign counter_bus.write_en  = write_en;

    csr_machine_regs machine_regs_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (machine_bus.bank)
    );

    csr_counters counters_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_retired (instr_retired),
        .bus           (counter_bus.bank),
        .cycle         (cycle)
    );

endmodule

`default_nettype wire

// File: bench/csr_file_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_file_checker (
    input  wire                        clk,
    input  wire                        arst_n,
    input  logic                       stall,
    input  logic                       write,
    input  csr_addr_pkg::csr_addr_t    csr,
    input  csr_data_pkg::csr_word_t    read_value,
    input  csr_data_pkg::csr_counter_t cycle
);
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    int   failures = 0;
    logic low_cycle_addr;
    logic high_cycle_addr;
    logic counter_addr;

    assign low_cycle_addr  = csr inside {`CSR_MCYCLE, `CSR_CYCLE, `CSR_TIME};
    assign high_cycle_addr = csr inside {`CSR_MCYCLEH, `CSR_CYCLEH, `CSR_TIMEH};
    assign counter_addr    = low_cycle_addr || high_cycle_addr
                          || (csr inside {`CSR_MINSTRET, `CSR_MINSTRETH,
                                          `CSR_INSTRET, `CSR_INSTRETH});

    // ------------------------------
    // counter behaviour
    // ------------------------------
    cycle_step: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> cycle == $past(cycle) + 64'd1)
        else begin failures++; $error("cycle did not advance by exactly one"); end

    cycle_low_read: assert property (@(posedge clk) disable iff (!arst_n)
        low_cycle_addr |-> read_value == cycle[31:0])
        else begin failures++; $error("low cycle read differs from cycle port"); end

    cycle_high_read: assert property (@(posedge clk) disable iff (!arst_n)
        high_cycle_addr |-> read_value == cycle[63:32])
        else begin failures++; $error("high cycle read differs from cycle port"); end

    // ------------------------------
    // stalled writes
    // ------------------------------
    // same address on the next edge shows whether the write landed.
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (stall && write && !counter_addr) ##1 $stable(csr) |-> $stable(read_value))
        else begin failures++; $error("stalled write changed the register"); end

endmodule

`default_nettype wire

// File: bench/csr_file_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_file_tb;
    import csr_addr_pkg::*;
    import csr_data_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = 400;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          stall;
    logic          write;
    csr_write_op_e write_op;
    csr_src_e      src;
    logic          instr_retired;
    csr_addr_t     csr;
    csr_word_t     rs1_value;
    csr_word_t     imm_value;
    csr_word_t     read_value;
    csr_counter_t  cycle;

    integer        seed = 32'h9513;
    int            errors = 0;
    logic          retire_on = 1'b0;
    csr_word_t     model_mem [0:4095]; // expected field values, already masked.
    csr_counter_t  model_cycle;
    csr_counter_t  model_instret;
    csr_addr_t     trap_regs [5] = '{`CSR_MSCRATCH, `CSR_MTVAL, `CSR_MEPC,
                                     `CSR_MTVEC, `CSR_MCAUSE};
    csr_addr_t     zero_regs [5] = '{`CSR_PMPCFG0, `CSR_PMPADDR0, `CSR_MHARTID,
                                     `CSR_MIP, `CSR_MVENDORID};

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_file csr_file_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .write         (write),
        .write_op      (write_op),
        .src           (src),
        .instr_retired (instr_retired),
        .csr           (csr),
        .rs1_value     (rs1_value),
        .imm_value     (imm_value),
        .read_value    (read_value),
        .cycle         (cycle)
    );

    bind csr_file csr_file_checker checker_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall      (stall),
        .write      (write),
        .csr        (csr),
        .read_value (read_value),
        .cycle      (cycle)
    );

    // ------------------------------
    // reference model
    // ------------------------------
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_cycle   = '0;
            model_instret = '0;
        end else begin
            model_cycle = model_cycle + 64'd1;
            if (instr_retired) model_instret = model_instret + 64'd1;
        end
    end

    function automatic csr_word_t field_mask(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS:  return 32'h0000_0088; // mpie and mie.
            `CSR_MIE:      return 32'h0000_0888;
            `CSR_MTVEC:    return 32'hFFFF_FFFD;
            `CSR_MSCRATCH: return 32'hFFFF_FFFF;
            `CSR_MEPC:     return 32'hFFFF_FFFC;
            `CSR_MCAUSE:   return 32'h8000_000F;
            `CSR_MTVAL:    return 32'hFFFF_FFFF;
            default:       return 32'h0000_0000; // counters and unimplemented.
        endcase
    endfunction

    function automatic csr_word_t expected_read(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS:                          return model_mem[addr] | 32'h0000_1800;
            `CSR_MISA:                             return `CSR_MISA_VALUE;
            `CSR_MCYCLE, `CSR_CYCLE, `CSR_TIME:    return model_cycle[31:0];
            `CSR_MCYCLEH, `CSR_CYCLEH, `CSR_TIMEH: return model_cycle[63:32];
            `CSR_MINSTRET, `CSR_INSTRET:           return model_instret[31:0];
            `CSR_MINSTRETH, `CSR_INSTRETH:         return model_instret[63:32];
            default:                               return model_mem[addr];
        endcase
    endfunction

    function automatic csr_word_t modified_value(input csr_write_op_e op,
                                                 input csr_word_t old_value,
                                                 input csr_word_t operand);
        case (op)
            CSR_OP_RS: return old_value | operand;
            CSR_OP_RC: return old_value & ~operand;
            default:   return operand;
        endcase
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic access(input csr_addr_t addr, input csr_write_op_e op, input csr_src_e s,
                          input csr_word_t value, input logic wr, input logic stl);
        csr_word_t expected;
        csr_word_t filler;
        filler = $random(seed);
        @(posedge clk);
        #2;
        csr           = addr;
        write_op      = op;
        src           = s;
        write         = wr;
        stall         = stl;
        rs1_value     = (s == CSR_SRC_REG) ? value : filler; // unused operand gets noise.
        imm_value     = (s == CSR_SRC_IMM) ? value : filler;
        instr_retired = retire_on && filler[7];
        @(negedge clk);
        expected = expected_read(addr);
        assert (read_value === expected) else begin
            $display("ERROR %0t: csr 0x%03h read 0x%08h, expected 0x%08h",
                     $time, addr, read_value, expected);
            errors++;
        end
        if (wr && !stl) model_mem[addr] = modified_value(op, expected, value) & field_mask(addr);
    endtask

    task automatic read_csr(input csr_addr_t addr);
        access(addr, CSR_OP_RW, CSR_SRC_REG, 32'h0, 1'b0, 1'b0);
    endtask

    initial begin
        arst_n        = 1'b0;
        stall         = 1'b0;
        write         = 1'b0;
        write_op      = CSR_OP_RW;
        src           = CSR_SRC_REG;
        instr_retired = 1'b0;
        csr           = '0;
        rs1_value     = '0;
        imm_value     = '0;
        for (int i = 0; i < 4096; i++) model_mem[i] = '0;
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;

        for (int round = 0; round < 3; round++) begin // read-write, both sources.
            for (int k = 0; k < 5; k++) begin
                access(trap_regs[k], CSR_OP_RW, ((round + k) % 2) ? CSR_SRC_IMM : CSR_SRC_REG,
                       $random(seed), 1'b1, 1'b0);
                read_csr(trap_regs[k]);
            end
        end

        for (int round = 0; round < 4; round++) begin // set and clear.
            access(`CSR_MSCRATCH, CSR_OP_RS, CSR_SRC_REG, $random(seed), 1'b1, 1'b0);
            access(`CSR_MSCRATCH, CSR_OP_RC, CSR_SRC_IMM, $random(seed), 1'b1, 1'b0);
            access(`CSR_MIE, CSR_OP_RS, CSR_SRC_IMM, $random(seed), 1'b1, 1'b0);
            access(`CSR_MIE, CSR_OP_RC, CSR_SRC_REG, $random(seed), 1'b1, 1'b0);
        end
        read_csr(`CSR_MIE);

        access(`CSR_MSTATUS, CSR_OP_RW, CSR_SRC_REG, 32'hFFFF_FFFF, 1'b1, 1'b0);
        foreach (trap_regs[k]) begin // stalled writes, then reread the same address.
            access(trap_regs[k], CSR_OP_RW, CSR_SRC_REG, $random(seed), 1'b1, 1'b1);
            read_csr(trap_regs[k]);
        end
        access(`CSR_MSTATUS, CSR_OP_RC, CSR_SRC_REG, 32'hFFFF_FFFF, 1'b1, 1'b1);
        read_csr(`CSR_MSTATUS);

        read_csr(`CSR_MCYCLE);
        read_csr(`CSR_CYCLE);
        read_csr(`CSR_TIME);
        read_csr(`CSR_MCYCLEH);
        read_csr(`CSR_CYCLEH);
        read_csr(`CSR_TIMEH);
        access(`CSR_MCYCLE, CSR_OP_RW, CSR_SRC_REG, 32'h0, 1'b1, 1'b0);
        read_csr(`CSR_MCYCLE);

        retire_on = 1'b1;
        for (int n = 0; n < 40; n++) begin
            if (n % 8 == 7) begin
                access(`CSR_MINSTRET, CSR_OP_RW, CSR_SRC_REG, $random(seed), 1'b1, 1'b0);
            end else if (n % 2) begin
                read_csr(`CSR_INSTRETH);
            end else begin
                read_csr(`CSR_MINSTRET);
            end
        end
        retire_on = 1'b0;
        read_csr(`CSR_INSTRET);
        read_csr(`CSR_MINSTRETH);

        read_csr(`CSR_MISA);
        access(`CSR_MSTATUS, CSR_OP_RW, CSR_SRC_IMM, $random(seed), 1'b1, 1'b0);
        read_csr(`CSR_MSTATUS);
        foreach (zero_regs[k]) begin
            access(zero_regs[k], CSR_OP_RW, CSR_SRC_REG, $random(seed), 1'b1, 1'b0);
            read_csr(zero_regs[k]);
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d read mismatches, %0d checker failures",
                 errors, csr_file_inst.checker_inst.failures);
        if (errors == 0 && csr_file_inst.checker_inst.failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/csr_addr_pkg.sv
src/csr_data_pkg.sv
src/csr_access_if.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_file.sv
bench/csr_file_checker.sv
bench/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - include_dirs:
      - src
    files:
      - src/csr_addr_pkg.sv
      - src/csr_data_pkg.sv
      - src/csr_access_if.sv
      - src/csr_machine_regs.sv
      - src/csr_counters.sv
      - src/csr_file.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - bench/csr_file_checker.sv
      - bench/csr_file_tb.sv
